// File: common/csr_pkg.sv
package csr_pkg;

    // Register address map
    localparam logic [7:0] addr_lut_frame     = 8'h00;
    localparam logic [7:0] addr_lut_addr_hi   = 8'h01;
    localparam logic [7:0] addr_lut_addr_lo   = 8'h02;
    localparam logic [7:0] addr_lut_wr        = 8'h03;
    // Operation command sits below the rectangle so bursts over the fields run straight
    localparam logic [7:0] addr_op_cmd        = 8'h04;
    localparam logic [7:0] addr_op_left_hi    = 8'h05;
    localparam logic [7:0] addr_op_left_lo    = 8'h06;
    localparam logic [7:0] addr_op_right_hi   = 8'h07;
    localparam logic [7:0] addr_op_right_lo   = 8'h08;
    localparam logic [7:0] addr_op_top_hi     = 8'h09;
    localparam logic [7:0] addr_op_top_lo     = 8'h0a;
    localparam logic [7:0] addr_op_bottom_hi  = 8'h0b;
    localparam logic [7:0] addr_op_bottom_lo  = 8'h0c;
    localparam logic [7:0] addr_op_param      = 8'h0d;
    localparam logic [7:0] addr_op_length     = 8'h0e;
    localparam logic [7:0] addr_enable        = 8'h0f;
    localparam logic [7:0] addr_cfg_vfp       = 8'h10;
    localparam logic [7:0] addr_cfg_vsync     = 8'h11;
    localparam logic [7:0] addr_cfg_vbp       = 8'h12;
    localparam logic [7:0] addr_cfg_vact_hi   = 8'h13;
    localparam logic [7:0] addr_cfg_vact_lo   = 8'h14;
    localparam logic [7:0] addr_cfg_hfp       = 8'h15;
    localparam logic [7:0] addr_cfg_hsync     = 8'h16;
    localparam logic [7:0] addr_cfg_hbp       = 8'h17;
    localparam logic [7:0] addr_cfg_hact_hi   = 8'h18;
    localparam logic [7:0] addr_cfg_hact_lo   = 8'h19;
    localparam logic [7:0] addr_cfg_fbytes_b2 = 8'h1a;
    localparam logic [7:0] addr_cfg_fbytes_b1 = 8'h1b;
    localparam logic [7:0] addr_cfg_fbytes_b0 = 8'h1c;
    localparam logic [7:0] addr_cfg_dfrc      = 8'h1d;
    localparam logic [7:0] addr_status        = 8'h1e;

    // Frame index of the default waveform
    localparam logic [5:0] lut_frame_reset = 6'd38;

    typedef struct packed {
        logic [7:0] addr;
        logic [7:0] wdata;
        logic       wen;
        logic       ren;
    } csr_req_t;

    typedef struct packed {
        logic [5:0]  frame;
        logic [11:0] addr;
        logic [7:0]  data;
        logic        we;
    } lut_wr_t;

    typedef struct packed {
        logic [11:0] left;
        logic [11:0] right;
        logic [11:0] top;
        logic [11:0] bottom;
        logic [7:0]  param;
        logic [7:0]  length;
        logic [7:0]  cmd;
        logic        valid;
    } op_req_t;

    typedef struct packed {
        logic mig_error;
        logic mif_error;
        logic sys_ready;
        logic op_busy;
        logic op_queue;
    } sys_status_t;

endpackage

// File: common/video_pkg.sv
package video_pkg;

    localparam int porch_w  = 8;
    localparam int act_w    = 12;
    localparam int fbytes_w = 24;
    localparam int dfrc_w   = 2;

    // Counter width covering three porches plus the active span
    localparam int count_w = act_w + 2;

    typedef struct packed {
        logic [porch_w-1:0]  vfp;
        logic [porch_w-1:0]  vsync;
        logic [porch_w-1:0]  vbp;
        logic [act_w-1:0]    vact;
        logic [porch_w-1:0]  hfp;
        logic [porch_w-1:0]  hsync;
        logic [porch_w-1:0]  hbp;
        logic [act_w-1:0]    hact;
        logic [fbytes_w-1:0] fbytes;
        logic [dfrc_w-1:0]   dfrc;
    } timing_cfg_t;

    typedef struct packed {
        logic hsync;
        logic vsync;
        logic de;
    } video_sync_t;

    // Panel of 1600 x 1200 pixels at four pixels per clock
    localparam timing_cfg_t timing_default = '{
        vfp:    8'd12,
        vsync:  8'd1,
        vbp:    8'd2,
        vact:   12'd1200,
        hfp:    8'd2,
        hsync:  8'd1,
        hbp:    8'd2,
        hact:   12'd400,
        fbytes: 24'd480000,
        dfrc:   2'd0
    };

endpackage

// File: csr/csr_regs.sv
`timescale 1ns/1ns

module csr_regs #(
    parameter bit       self_boot      = 1'b0,
    parameter bit [5:0] lut_frame_init = csr_pkg::lut_frame_reset
) (
    input  logic                    clk,
    input  logic                    rst,
    input  csr_pkg::csr_req_t       csr_req,
    input  csr_pkg::sys_status_t    status,
    output logic [7:0]              rdata,
    output csr_pkg::lut_wr_t        lut_wr,
    output csr_pkg::op_req_t        op_req,
    output video_pkg::timing_cfg_t  timing_cfg,
    output logic                    en
);

    logic [5:0]  lut_frame;
    logic [11:0] lut_addr;
    logic [7:0]  lut_data;
    logic        lut_we;
    logic [11:0] op_left;
    logic [11:0] op_right;
    logic [11:0] op_top;
    logic [11:0] op_bottom;
    logic [7:0]  op_param;
    logic [7:0]  op_length;
    logic [7:0]  op_cmd;
    logic        op_valid;
    logic [7:0]  wd;

    assign wd = csr_req.wdata;

    // Control and timing configuration
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lut_frame  <= lut_frame_init;
            lut_we     <= 1'b0;
            op_valid   <= 1'b0;
            en         <= self_boot;
            timing_cfg <= self_boot ? video_pkg::timing_default : '0;
        end else begin
            lut_we   <= csr_req.wen && (csr_req.addr == csr_pkg::addr_lut_wr);
            op_valid <= csr_req.wen && (csr_req.addr == csr_pkg::addr_op_cmd);
            if (csr_req.wen) begin
                case (csr_req.addr)
                    csr_pkg::addr_lut_frame:     lut_frame <= wd[5:0];
                    csr_pkg::addr_enable:        en <= wd[0];
                    csr_pkg::addr_cfg_vfp:       timing_cfg.vfp <= wd;
                    csr_pkg::addr_cfg_vsync:     timing_cfg.vsync <= wd;
                    csr_pkg::addr_cfg_vbp:       timing_cfg.vbp <= wd;
                    csr_pkg::addr_cfg_vact_hi:   timing_cfg.vact[11:8] <= wd[3:0];
                    csr_pkg::addr_cfg_vact_lo:   timing_cfg.vact[7:0] <= wd;
                    csr_pkg::addr_cfg_hfp:       timing_cfg.hfp <= wd;
                    csr_pkg::addr_cfg_hsync:     timing_cfg.hsync <= wd;
                    csr_pkg::addr_cfg_hbp:       timing_cfg.hbp <= wd;
                    csr_pkg::addr_cfg_hact_hi:   timing_cfg.hact[11:8] <= wd[3:0];
                    csr_pkg::addr_cfg_hact_lo:   timing_cfg.hact[7:0] <= wd;
                    csr_pkg::addr_cfg_fbytes_b2: timing_cfg.fbytes[23:16] <= wd;
                    csr_pkg::addr_cfg_fbytes_b1: timing_cfg.fbytes[15:8] <= wd;
                    csr_pkg::addr_cfg_fbytes_b0: timing_cfg.fbytes[7:0] <= wd;
                    csr_pkg::addr_cfg_dfrc:      timing_cfg.dfrc <= wd[1:0];
                    default: ;
                endcase
            end
        end
    end

    // LUT and operation payload fields
    always_ff @(posedge clk) begin
        if (csr_req.wen) begin
            case (csr_req.addr)
                csr_pkg::addr_lut_addr_hi:  lut_addr[11:8] <= wd[3:0];
                csr_pkg::addr_lut_addr_lo:  lut_addr[7:0] <= wd;
                csr_pkg::addr_lut_wr:       lut_data <= wd;
                csr_pkg::addr_op_left_hi:   op_left[11:8] <= wd[3:0];
                csr_pkg::addr_op_left_lo:   op_left[7:0] <= wd;
                csr_pkg::addr_op_right_hi:  op_right[11:8] <= wd[3:0];
                csr_pkg::addr_op_right_lo:  op_right[7:0] <= wd;
                csr_pkg::addr_op_top_hi:    op_top[11:8] <= wd[3:0];
                csr_pkg::addr_op_top_lo:    op_top[7:0] <= wd;
                csr_pkg::addr_op_bottom_hi: op_bottom[11:8] <= wd[3:0];
                csr_pkg::addr_op_bottom_lo: op_bottom[7:0] <= wd;
                csr_pkg::addr_op_param:     op_param <= wd;
                csr_pkg::addr_op_length:    op_length <= wd;
                csr_pkg::addr_op_cmd:       op_cmd <= wd;
                default: ;
            endcase
        end
    end

    // Strobe and unmapped addresses read back as zero
    always_comb begin
        case (csr_req.addr)
            csr_pkg::addr_lut_frame:     rdata = {2'b00, lut_frame};
            csr_pkg::addr_lut_addr_hi:   rdata = {4'h0, lut_addr[11:8]};
            csr_pkg::addr_lut_addr_lo:   rdata = lut_addr[7:0];
            csr_pkg::addr_op_left_hi:    rdata = {4'h0, op_left[11:8]};
            csr_pkg::addr_op_left_lo:    rdata = op_left[7:0];
            csr_pkg::addr_op_right_hi:   rdata = {4'h0, op_right[11:8]};
            csr_pkg::addr_op_right_lo:   rdata = op_right[7:0];
            csr_pkg::addr_op_top_hi:     rdata = {4'h0, op_top[11:8]};
            csr_pkg::addr_op_top_lo:     rdata = op_top[7:0];
            csr_pkg::addr_op_bottom_hi:  rdata = {4'h0, op_bottom[11:8]};
            csr_pkg::addr_op_bottom_lo:  rdata = op_bottom[7:0];
            csr_pkg::addr_op_param:      rdata = op_param;
            csr_pkg::addr_op_length:     rdata = op_length;
            csr_pkg::addr_enable:        rdata = {7'd0, en};
            csr_pkg::addr_cfg_vfp:       rdata = timing_cfg.vfp;
            csr_pkg::addr_cfg_vsync:     rdata = timing_cfg.vsync;
            csr_pkg::addr_cfg_vbp:       rdata = timing_cfg.vbp;
            csr_pkg::addr_cfg_vact_hi:   rdata = {4'h0, timing_cfg.vact[11:8]};
            csr_pkg::addr_cfg_vact_lo:   rdata = timing_cfg.vact[7:0];
            csr_pkg::addr_cfg_hfp:       rdata = timing_cfg.hfp;
            csr_pkg::addr_cfg_hsync:     rdata = timing_cfg.hsync;
            csr_pkg::addr_cfg_hbp:       rdata = timing_cfg.hbp;
            csr_pkg::addr_cfg_hact_hi:   rdata = {4'h0, timing_cfg.hact[11:8]};
            csr_pkg::addr_cfg_hact_lo:   rdata = timing_cfg.hact[7:0];
            csr_pkg::addr_cfg_fbytes_b2: rdata = timing_cfg.fbytes[23:16];
            csr_pkg::addr_cfg_fbytes_b1: rdata = timing_cfg.fbytes[15:8];
            csr_pkg::addr_cfg_fbytes_b0: rdata = timing_cfg.fbytes[7:0];
            csr_pkg::addr_cfg_dfrc:      rdata = {6'd0, timing_cfg.dfrc};
            csr_pkg::addr_status:        rdata = {status.mig_error, status.mif_error,
                                                  status.sys_ready, status.op_busy,
                                                  status.op_queue, 2'b00, en};
            default:                     rdata = 8'd0;
        endcase
    end

    assign lut_wr = '{frame: lut_frame, addr: lut_addr, data: lut_data, we: lut_we};
    assign op_req = '{left: op_left, right: op_right, top: op_top, bottom: op_bottom,
                      param: op_param, length: op_length, cmd: op_cmd, valid: op_valid};

endmodule

// File: epd_ctrl_top.f
common/csr_pkg.sv
common/video_pkg.sv
spi/spi_target.sv
csr/csr_regs.sv
logic/frame_timing.sv
logic/epd_ctrl_top.sv
test/tb_epd_ctrl_top.sv

// File: logic/epd_ctrl_top.sv
`timescale 1ns/1ns

module epd_ctrl_top #(
    parameter bit       self_boot      = 1'b0,
    parameter bit [5:0] lut_frame_init = csr_pkg::lut_frame_reset
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   spi_cs,
    input  logic                   spi_sck,
    input  logic                   spi_mosi,
    output logic                   spi_miso,
    input  csr_pkg::sys_status_t   status,
    output csr_pkg::lut_wr_t       lut_wr,
    output csr_pkg::op_req_t       op_req,
    output video_pkg::video_sync_t video_sync
);

    csr_pkg::csr_req_t      csr_req;
    logic [7:0]             rdata;
    video_pkg::timing_cfg_t timing_cfg;
    logic                   en;

    spi_target u_spi_target (
        .clk      (clk),
        .rst      (rst),
        .spi_cs   (spi_cs),
        .spi_sck  (spi_sck),
        .spi_mosi (spi_mosi),
        .rdata    (rdata),
        .spi_miso (spi_miso),
        .csr_req  (csr_req)
    );

    csr_regs #(
        .self_boot      (self_boot),
        .lut_frame_init (lut_frame_init)
    ) u_csr_regs (
        .clk        (clk),
        .rst        (rst),
        .csr_req    (csr_req),
        .status     (status),
        .rdata      (rdata),
        .lut_wr     (lut_wr),
        .op_req     (op_req),
        .timing_cfg (timing_cfg),
        .en         (en)
    );

    frame_timing u_frame_timing (
        .clk        (clk),
        .rst        (rst),
        .en         (en),
        .timing_cfg (timing_cfg),
        .video_sync (video_sync)
    );

endmodule

// File: logic/frame_timing.sv
`timescale 1ns/1ns

module frame_timing (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   en,
    input  video_pkg::timing_cfg_t timing_cfg,
    output video_pkg::video_sync_t video_sync
);

    localparam int cw = video_pkg::count_w;

    logic [cw-1:0] h_cnt;
    logic [cw-1:0] v_cnt;
    logic [cw-1:0] hs_end;
    logic [cw-1:0] ha_start;
    logic [cw-1:0] h_total;
    logic [cw-1:0] vs_end;
    logic [cw-1:0] va_start;
    logic [cw-1:0] v_total;
    logic          h_last;
    logic          v_last;

    // Segment boundaries with the front porch first
    assign hs_end   = cw'(timing_cfg.hfp) + cw'(timing_cfg.hsync);
    assign ha_start = hs_end + cw'(timing_cfg.hbp);
    assign h_total  = ha_start + cw'(timing_cfg.hact);
    assign vs_end   = cw'(timing_cfg.vfp) + cw'(timing_cfg.vsync);
    assign va_start = vs_end + cw'(timing_cfg.vbp);
    assign v_total  = va_start + cw'(timing_cfg.vact);

    assign h_last = (h_cnt == h_total - cw'(1));
    assign v_last = (v_cnt == v_total - cw'(1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            h_cnt      <= '0;
            v_cnt      <= '0;
            video_sync <= '0;
        end else if (!en) begin
            // Held at the frame start until enabled again
            h_cnt      <= '0;
            v_cnt      <= '0;
            video_sync <= '0;
        end else begin
            if (h_last) begin
                h_cnt <= '0;
                v_cnt <= v_last ? '0 : v_cnt + cw'(1);
            end else begin
                h_cnt <= h_cnt + cw'(1);
            end
            video_sync.hsync <= (h_cnt >= cw'(timing_cfg.hfp)) && (h_cnt < hs_end);
            video_sync.vsync <= (v_cnt >= cw'(timing_cfg.vfp)) && (v_cnt < vs_end);
            video_sync.de    <= (h_cnt >= ha_start) && (h_cnt < h_total)
                                && (v_cnt >= va_start) && (v_cnt < v_total);
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f epd_ctrl_top.f --top-module tb_epd_ctrl_top -o sim_epd \
    > build.log 2>&1 \
    && ./obj_dir/sim_epd > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or run failed"; exit 1; }
cat sim.log
grep -q "^SIMULATION PASSED$" sim.log \
    && echo "Test passed" \
    || { echo "Test failed"; exit 1; }

// File: spi/spi_target.sv
`timescale 1ns/1ns

module spi_target (
    input  logic              clk,
    input  logic              rst,
    input  logic              spi_cs,
    input  logic              spi_sck,
    input  logic              spi_mosi,
    input  logic [7:0]        rdata,
    output logic              spi_miso,
    output csr_pkg::csr_req_t csr_req
);

    localparam logic addr_phase = 1'b0;
    localparam logic data_phase = 1'b1;

    logic [1:0] cs_sync;
    logic [1:0] sck_sync;
    logic [1:0] mosi_sync;
    logic       last_sck;
    logic       cs;
    logic       sck_rise;
    logic       sck_fall;
    logic       byte_done;

    logic       phase;
    logic [2:0] bit_cnt;
    logic [6:0] rx;
    logic [7:0] rx_next;
    logic [7:0] tx;
    logic [7:0] addr;
    logic [7:0] wdata;
    logic       wen;
    logic       ren;
    logic       auto_inc;

    // Pins come up at their idle levels with CS and SCK high
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cs_sync  <= 2'b11;
            sck_sync <= 2'b11;
            last_sck <= 1'b1;
        end else begin
            cs_sync  <= {cs_sync[0], spi_cs};
            sck_sync <= {sck_sync[0], spi_sck};
            last_sck <= sck_sync[1];
        end
    end

    always_ff @(posedge clk) begin
        mosi_sync <= {mosi_sync[0], spi_mosi};
    end

    assign cs        = cs_sync[1];
    assign sck_rise  = !cs && !last_sck && sck_sync[1];
    assign sck_fall  = !cs && last_sck && !sck_sync[1];
    assign rx_next   = {rx, mosi_sync[1]};
    assign byte_done = sck_rise && (bit_cnt == 3'd7);

    // Strobe registers keep the address so a burst repeats the strobe
    assign auto_inc = (addr != csr_pkg::addr_lut_wr) && (addr != csr_pkg::addr_op_cmd);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase    <= addr_phase;
            bit_cnt  <= 3'd0;
            ren      <= 1'b0;
            wen      <= 1'b0;
            tx       <= 8'hff;
            spi_miso <= 1'b1;
        end else begin
            ren <= 1'b0;
            wen <= 1'b0;
            // Read data lands in the shifter one cycle after the request
            if (ren) begin
                tx <= rdata;
            end
            if (cs) begin
                phase    <= addr_phase;
                bit_cnt  <= 3'd0;
                tx       <= 8'hff;
                spi_miso <= 1'b1;
            end else if (sck_rise) begin
                bit_cnt <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7) begin
                    ren   <= (phase == addr_phase);
                    wen   <= (phase == data_phase);
                    phase <= data_phase;
                end
            end else if (sck_fall) begin
                spi_miso <= tx[7];
                tx       <= {tx[6:0], 1'b0};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sck_rise) begin
            rx <= rx_next[6:0];
        end
        if (byte_done && phase == data_phase) begin
            wdata <= rx_next;
        end
        if (byte_done && phase == addr_phase) begin
            addr <= rx_next;
        end else if (wen && auto_inc) begin
            addr <= addr + 8'd1;
        end
    end

    assign csr_req = '{addr: addr, wdata: wdata, wen: wen, ren: ren};

endmodule

// File: test/tb_epd_ctrl_top.sv
`timescale 1ns/1ns

module tb_epd_ctrl_top;

    localparam int half_clks = 8;
    // SPI bytes over all tests rounded up
    localparam int spi_bytes = 140;

    // Small timing for the frame test
    localparam int t_vfp   = 2;
    localparam int t_vsync = 1;
    localparam int t_vbp   = 1;
    localparam int t_vact  = 3;
    localparam int t_hfp   = 3;
    localparam int t_hsync = 2;
    localparam int t_hbp   = 2;
    localparam int t_hact  = 10;
    localparam int line_clks   = t_hfp + t_hsync + t_hbp + t_hact;
    localparam int frame_lines = t_vfp + t_vsync + t_vbp + t_vact;
    localparam int frame_clks  = line_clks * frame_lines;
    localparam int limit_clks  = spi_bytes * 16 * half_clks + 2 * frame_clks + 4000;

    logic                   clk;
    logic                   rst;
    logic                   spi_cs;
    logic                   spi_sck;
    logic                   spi_mosi;
    logic                   spi_miso;
    csr_pkg::sys_status_t   status;
    csr_pkg::lut_wr_t       lut_wr;
    csr_pkg::op_req_t       op_req;
    video_pkg::video_sync_t video_sync;

    logic [31:0]      seed;
    logic [7:0]       model [0:255];
    logic [7:0]       wbuf [0:31];
    csr_pkg::lut_wr_t lut_exp [$];
    csr_pkg::op_req_t op_exp [$];
    int               errors;
    int               lut_pulses;
    int               op_pulses;

    epd_ctrl_top #(
        .self_boot      (1'b0),
        .lut_frame_init (csr_pkg::lut_frame_reset)
    ) uut (
        .clk        (clk),
        .rst        (rst),
        .spi_cs     (spi_cs),
        .spi_sck    (spi_sck),
        .spi_mosi   (spi_mosi),
        .spi_miso   (spi_miso),
        .status     (status),
        .lut_wr     (lut_wr),
        .op_req     (op_req),
        .video_sync (video_sync)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic check(input string what, input logic [127:0] got, input logic [127:0] exp);
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // Expected read byte from the written values and the field widths
    function automatic logic [7:0] expected_read(input logic [7:0] addr);
        logic [7:0] v;
        logic [7:0] en_v;
        v    = model[addr];
        en_v = model[csr_pkg::addr_enable];
        case (addr)
            csr_pkg::addr_lut_frame: return {2'b00, v[5:0]};
            csr_pkg::addr_lut_addr_hi, csr_pkg::addr_op_left_hi, csr_pkg::addr_op_right_hi,
            csr_pkg::addr_op_top_hi, csr_pkg::addr_op_bottom_hi, csr_pkg::addr_cfg_vact_hi,
            csr_pkg::addr_cfg_hact_hi: return {4'h0, v[3:0]};
            csr_pkg::addr_enable:    return {7'd0, v[0]};
            csr_pkg::addr_cfg_dfrc:  return {6'd0, v[1:0]};
            csr_pkg::addr_status:    return {status.mig_error, status.mif_error, status.sys_ready,
                                             status.op_busy, status.op_queue, 2'b00, en_v[0]};
            csr_pkg::addr_lut_wr, csr_pkg::addr_op_cmd: return 8'h00;
            default: return (addr < csr_pkg::addr_status) ? v : 8'h00;
        endcase
    endfunction

    // Sends one mode 3 byte starting on a falling clk edge
    task automatic spi_byte(input logic [7:0] tx_byte, input bit last, output logic [7:0] rx_byte);
        for (int i = 7; i >= 0; i--) begin
            spi_sck  = 1'b0;
            spi_mosi = tx_byte[i];
            repeat (half_clks) @(negedge clk);
            rx_byte[i] = spi_miso;
            spi_sck    = 1'b1;
            // CS rises together with the last SCK edge so no write follows the read
            if (last && i == 0) begin
                spi_cs = 1'b1;
            end
            repeat (half_clks) @(negedge clk);
        end
    endtask

    task automatic spi_write_burst(input logic [7:0] addr, input int count);
        logic [7:0] dummy;
        logic [7:0] a;
        a      = addr;
        spi_cs = 1'b0;
        repeat (half_clks) @(negedge clk);
        spi_byte(addr, 1'b0, dummy);
        for (int i = 0; i < count; i++) begin
            spi_byte(wbuf[i], 1'b0, dummy);
            model[a] = wbuf[i];
            if (a != csr_pkg::addr_lut_wr && a != csr_pkg::addr_op_cmd) begin
                a = a + 8'd1;
            end
        end
        spi_cs = 1'b1;
        repeat (2 * half_clks) @(negedge clk);
    endtask

    task automatic spi_read(input logic [7:0] addr, output logic [7:0] value);
        logic [7:0] dummy;
        spi_cs = 1'b0;
        repeat (half_clks) @(negedge clk);
        spi_byte(addr, 1'b0, dummy);
        spi_byte(8'h00, 1'b1, value);
        repeat (half_clks) @(negedge clk);
    endtask

    task automatic read_and_compare(input logic [7:0] addr);
        logic [7:0] value;
        spi_read(addr, value);
        check($sformatf("read of register %02h", addr), 128'(value), 128'(expected_read(addr)));
    endtask

    task automatic expect_sync_low(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check("video sync while disabled", 128'(video_sync), 128'(0));
        end
    endtask

    // Periods of hsync and vsync and the de run per active line
    task automatic measure_frames(input int cycles);
        int   hs_last;
        int   hs_rises;
        int   vs_last;
        int   vs_rises;
        int   de_run;
        int   de_total;
        logic prev_hs;
        logic prev_vs;
        logic prev_de;
        hs_last  = -1;
        hs_rises = 0;
        vs_last  = -1;
        vs_rises = 0;
        de_run   = 0;
        de_total = 0;
        prev_hs  = video_sync.hsync;
        prev_vs  = video_sync.vsync;
        prev_de  = video_sync.de;
        for (int t = 0; t < cycles; t++) begin
            @(negedge clk);
            if (video_sync.hsync && !prev_hs) begin
                if (hs_last >= 0) begin
                    check("clocks between hsync pulses", 128'(t - hs_last), 128'(line_clks));
                end
                hs_last = t;
                hs_rises++;
            end
            if (video_sync.de) begin
                de_run++;
            end else if (prev_de) begin
                check("de clocks in an active line", 128'(de_run), 128'(t_hact));
                de_total += de_run;
                de_run = 0;
            end
            if (video_sync.vsync && !prev_vs) begin
                if (vs_last >= 0) begin
                    check("lines between vsync pulses", 128'((t - vs_last) / line_clks),
                          128'(frame_lines));
                    check("clocks between vsync pulses", 128'(t - vs_last), 128'(frame_clks));
                    check("de clocks in a frame", 128'(de_total), 128'(t_hact * t_vact));
                end
                vs_last = t;
                vs_rises++;
                de_total = 0;
            end
            prev_hs = video_sync.hsync;
            prev_vs = video_sync.vsync;
            prev_de = video_sync.de;
        end
        if (hs_rises < 2) begin
            errors++;
            $display("Frame timing gave fewer than two hsync pulses in %0d clocks", cycles);
        end
        if (vs_rises < 2) begin
            errors++;
            $display("Frame timing gave fewer than two vsync pulses in %0d clocks", cycles);
        end
    endtask

    // Every strobe pulse must match the next queued expectation
    always @(negedge clk) begin
        if (!rst && lut_wr.we) begin
            lut_pulses++;
            if (lut_exp.size() == 0) begin
                errors++;
                $display("Unexpected LUT write pulse at %0t ns", $time);
            end else begin
                check("LUT write", 128'(lut_wr), 128'(lut_exp.pop_front()));
            end
        end
        if (!rst && op_req.valid) begin
            op_pulses++;
            if (op_exp.size() == 0) begin
                errors++;
                $display("Unexpected operation request at %0t ns", $time);
            end else begin
                check("operation request", 128'(op_req), 128'(op_exp.pop_front()));
            end
        end
    end

    initial begin
        #(limit_clks * 8);
        $display("Timeout: the tests did not complete within %0d clocks", limit_clks);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        csr_pkg::lut_wr_t lut_e;
        csr_pkg::op_req_t op_e;
        logic [31:0]      r;
        rst        = 1'b1;
        spi_cs     = 1'b1;
        spi_sck    = 1'b1;
        spi_mosi   = 1'b0;
        status     = '0;
        seed       = 32'h89b;
        errors     = 0;
        lut_pulses = 0;
        op_pulses  = 0;
        for (int i = 0; i < 256; i++) begin
            model[i] = 8'h00;
        end
        model[csr_pkg::addr_lut_frame] = {2'b00, csr_pkg::lut_frame_reset};
        repeat (10) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        // Reset defaults
        read_and_compare(csr_pkg::addr_lut_frame);
        read_and_compare(csr_pkg::addr_enable);
        read_and_compare(csr_pkg::addr_status);
        expect_sync_low(32);

        // Burst over the rectangle and timing registers, then read back one by one
        for (int i = 0; i < 25; i++) begin
            r = next_random();
            wbuf[i] = r[7:0];
        end
        spi_write_burst(csr_pkg::addr_op_left_hi, 25);
        for (int a = csr_pkg::addr_op_left_hi; a <= csr_pkg::addr_cfg_dfrc; a++) begin
            read_and_compare(8'(a));
        end

        // LUT strobe keeps its address through the burst
        for (int i = 0; i < 3; i++) begin
            r = next_random();
            wbuf[i] = r[7:0];
        end
        spi_write_burst(csr_pkg::addr_lut_frame, 3);
        for (int i = 0; i < 3; i++) begin
            r = next_random();
            wbuf[i]     = r[7:0];
            lut_e.frame = model[csr_pkg::addr_lut_frame][5:0];
            lut_e.addr  = {model[csr_pkg::addr_lut_addr_hi][3:0], model[csr_pkg::addr_lut_addr_lo]};
            lut_e.data  = r[7:0];
            lut_e.we    = 1'b1;
            lut_exp.push_back(lut_e);
        end
        spi_write_burst(csr_pkg::addr_lut_wr, 3);
        check("LUT write pulses", 128'(lut_pulses), 128'(3));

        // Operation request
        for (int i = 0; i < 10; i++) begin
            r = next_random();
            wbuf[i] = r[7:0];
        end
        spi_write_burst(csr_pkg::addr_op_left_hi, 10);
        r = next_random();
        op_e.left   = {model[csr_pkg::addr_op_left_hi][3:0], model[csr_pkg::addr_op_left_lo]};
        op_e.right  = {model[csr_pkg::addr_op_right_hi][3:0], model[csr_pkg::addr_op_right_lo]};
        op_e.top    = {model[csr_pkg::addr_op_top_hi][3:0], model[csr_pkg::addr_op_top_lo]};
        op_e.bottom = {model[csr_pkg::addr_op_bottom_hi][3:0], model[csr_pkg::addr_op_bottom_lo]};
        op_e.param  = model[csr_pkg::addr_op_param];
        op_e.length = model[csr_pkg::addr_op_length];
        op_e.cmd    = r[7:0];
        op_e.valid  = 1'b1;
        op_exp.push_back(op_e);
        wbuf[0] = r[7:0];
        spi_write_burst(csr_pkg::addr_op_cmd, 1);
        check("operation request pulses", 128'(op_pulses), 128'(1));

        // Status inputs
        repeat (4) begin
            r = next_random();
            status = csr_pkg::sys_status_t'(r[4:0]);
            read_and_compare(csr_pkg::addr_status);
        end

        // Frame timing is loaded while disabled
        wbuf[0]  = 8'd0;
        wbuf[1]  = 8'(t_vfp);
        wbuf[2]  = 8'(t_vsync);
        wbuf[3]  = 8'(t_vbp);
        wbuf[4]  = 8'd0;
        wbuf[5]  = 8'(t_vact);
        wbuf[6]  = 8'(t_hfp);
        wbuf[7]  = 8'(t_hsync);
        wbuf[8]  = 8'(t_hbp);
        wbuf[9]  = 8'd0;
        wbuf[10] = 8'(t_hact);
        spi_write_burst(csr_pkg::addr_enable, 11);
        wbuf[0] = 8'd1;
        spi_write_burst(csr_pkg::addr_enable, 1);
        measure_frames(2 * frame_clks + line_clks);
        wbuf[0] = 8'd0;
        spi_write_burst(csr_pkg::addr_enable, 1);
        expect_sync_low(line_clks);

        repeat (4) @(negedge clk);
        check("LUT writes still expected", 128'(lut_exp.size()), 128'(0));
        check("operation requests still expected", 128'(op_exp.size()), 128'(0));

        $display("Errors: %0d, LUT write pulses: %0d, operation requests: %0d",
                 errors, lut_pulses, op_pulses);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
